//--- source/alu_lab_pkg.sv
package alu_lab_pkg;

    // Datapath widths, fixed by the switch field layout
    localparam int DATA_W = 4;
    localparam int OP_W   = 6;
    localparam int SW_W   = 16;

    // Where each field sits on the slide switches
    localparam int SW_A_LSB  = 0;
    localparam int SW_B_LSB  = 4;
    localparam int SW_OP_LSB = 8;

    // Operands and result
    typedef logic [DATA_W-1:0] operand_t;
    // ALU function code
    typedef logic [OP_W-1:0]   alu_op_t;
    // Whole switch bank
    typedef logic [SW_W-1:0]   switch_t;

    // MIPS-style function codes
    localparam alu_op_t OP_ADD = 6'b100000;
    localparam alu_op_t OP_SUB = 6'b100010;
    localparam alu_op_t OP_AND = 6'b100100;
    localparam alu_op_t OP_OR  = 6'b100101;
    localparam alu_op_t OP_XOR = 6'b100110;
    localparam alu_op_t OP_NOR = 6'b100111;
    // Shifts use the lower code space
    localparam alu_op_t OP_SRA = 6'b000011;
    localparam alu_op_t OP_SRL = 6'b000010;

    // Load order of the input controller
    typedef enum logic [1:0]
    {
        ST_WAIT_A  = 2'd0,
        ST_WAIT_B  = 2'd1,
        ST_WAIT_OP = 2'd2
    } load_state_t;

endpackage

//--- source/button_pulse.sv
`timescale 1ns/1ps

module button_pulse
(
    input  logic i_clock,
    input  logic i_rst,
    input  logic i_button,
    output logic o_pulse
);

    // Two-flop synchronizer stages
    logic sync_meta;
    logic sync_level;
    // Previous synchronized level, for edge detection
    logic level_dly;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            sync_meta  <= 1'b0;
            sync_level <= 1'b0;
            level_dly  <= 1'b0;
            o_pulse    <= 1'b0;
        end
        else
        begin
            sync_meta  <= i_button;
            sync_level <= sync_meta;
            level_dly  <= sync_level;
            // High for one cycle on a low-to-high change only
            o_pulse    <= sync_level & ~level_dly;
        end
    end

endmodule

//--- source/alu_input_ctrl.sv
`timescale 1ns/1ps

module alu_input_ctrl
    import alu_lab_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_rst,
    input  switch_t  i_sw,
    input  logic     i_load_a,
    input  logic     i_load_b,
    input  logic     i_load_op,
    output operand_t o_alu_a,
    output operand_t o_alu_b,
    output alu_op_t  o_alu_op,
    output logic     o_start
);

    load_state_t state;
    load_state_t state_next;

    // Load enables, only when the pulse is the expected one
    logic take_a;
    logic take_b;
    logic take_op;

    // Switch fields
    operand_t sw_a;
    operand_t sw_b;
    alu_op_t  sw_op;

    assign sw_a  = i_sw[SW_A_LSB +: DATA_W];
    assign sw_b  = i_sw[SW_B_LSB +: DATA_W];
    assign sw_op = i_sw[SW_OP_LSB +: OP_W];

    // Next state and accepted loads
    always_comb
    begin
        state_next = state;
        take_a     = 1'b0;
        take_b     = 1'b0;
        take_op    = 1'b0;
        case (state)
            ST_WAIT_A:
            begin
                // B and opcode pulses dropped here
                if (i_load_a)
                begin
                    take_a     = 1'b1;
                    state_next = ST_WAIT_B;
                end
            end
            ST_WAIT_B:
            begin
                if (i_load_b)
                begin
                    take_b     = 1'b1;
                    state_next = ST_WAIT_OP;
                end
            end
            ST_WAIT_OP:
            begin
                // Opcode completes the sequence, back to A
                if (i_load_op)
                begin
                    take_op    = 1'b1;
                    state_next = ST_WAIT_A;
                end
            end
            default:
            begin
                state_next = ST_WAIT_A;
            end
        endcase
    end

    // State, held operands and start strobe
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            state    <= ST_WAIT_A;
            o_alu_a  <= '0;
            o_alu_b  <= '0;
            o_alu_op <= '0;
            o_start  <= 1'b0;
        end
        else
        begin
            state   <= state_next;
            // One cycle after the opcode load
            o_start <= take_op;
            if (take_a)
                o_alu_a <= sw_a;
            if (take_b)
                o_alu_b <= sw_b;
            if (take_op)
                o_alu_op <= sw_op;
        end
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu
    import alu_lab_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  operand_t i_alu_a,
    input  operand_t i_alu_b,
    input  alu_op_t  i_alu_op,
    output operand_t o_alu_result,
    output logic     o_overflow_flag,
    output logic     o_result_valid
);

    // Sum and difference, truncated to DATA_W
    operand_t sum;
    operand_t diff;
    // Signed overflow of each
    logic     add_ovf;
    logic     sub_ovf;
    // Combinational result before the output register
    operand_t result_next;
    logic     ovf_next;

    assign sum  = i_alu_a + i_alu_b;
    assign diff = i_alu_a - i_alu_b;

    // Same signs in, other sign out
    assign add_ovf = (i_alu_a[DATA_W-1] == i_alu_b[DATA_W-1])
                   && (sum[DATA_W-1] != i_alu_a[DATA_W-1]);
    // Signs differ, result flips away from A
    assign sub_ovf = (i_alu_a[DATA_W-1] != i_alu_b[DATA_W-1])
                   && (diff[DATA_W-1] != i_alu_a[DATA_W-1]);

    // Operation select
    always_comb
    begin
        result_next = '0;
        ovf_next    = 1'b0;
        case (i_alu_op)
            OP_ADD:
            begin
                result_next = sum;
                ovf_next    = add_ovf;
            end
            OP_SUB:
            begin
                result_next = diff;
                ovf_next    = sub_ovf;
            end
            OP_AND: result_next = i_alu_a & i_alu_b;
            OP_OR:  result_next = i_alu_a | i_alu_b;
            OP_XOR: result_next = i_alu_a ^ i_alu_b;
            OP_NOR: result_next = ~(i_alu_a | i_alu_b);
            // Amount is B unsigned, large shifts fill with sign
            OP_SRA: result_next = operand_t'($signed(i_alu_a) >>> i_alu_b);
            // Large shifts give zero
            OP_SRL: result_next = i_alu_a >> i_alu_b;
            // Unknown code, zero result
            default:
            begin
                result_next = '0;
                ovf_next    = 1'b0;
            end
        endcase
    end

    // Result and flag hold between starts
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            o_alu_result    <= '0;
            o_overflow_flag <= 1'b0;
            o_result_valid  <= 1'b0;
        end
        else
        begin
            o_result_valid <= i_start;
            if (i_start)
            begin
                o_alu_result    <= result_next;
                o_overflow_flag <= ovf_next;
            end
        end
    end

endmodule

//--- source/alu_top.sv
`timescale 1ns/1ps

module alu_top
    import alu_lab_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_rst,
    input  switch_t  i_sw,
    input  logic     i_button_a,
    input  logic     i_button_b,
    input  logic     i_button_op,
    output operand_t o_alu_a,
    output operand_t o_alu_b,
    output alu_op_t  o_alu_op,
    output operand_t o_alu_result,
    output logic     o_overflow_flag,
    output logic     o_result_valid
);

    // One pulse per press
    logic load_a_pulse;
    logic load_b_pulse;
    logic load_op_pulse;
    // Controller to ALU strobe
    logic alu_start;

    // Button A
    button_pulse u_pulse_a
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_button (i_button_a),
        .o_pulse  (load_a_pulse)
    );

    // Button B
    button_pulse u_pulse_b
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_button (i_button_b),
        .o_pulse  (load_b_pulse)
    );

    // Opcode button
    button_pulse u_pulse_op
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_button (i_button_op),
        .o_pulse  (load_op_pulse)
    );

    // Held operands go to the LEDs and the ALU
    alu_input_ctrl u_ctrl
    (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_sw      (i_sw),
        .i_load_a  (load_a_pulse),
        .i_load_b  (load_b_pulse),
        .i_load_op (load_op_pulse),
        .o_alu_a   (o_alu_a),
        .o_alu_b   (o_alu_b),
        .o_alu_op  (o_alu_op),
        .o_start   (alu_start)
    );

    alu u_alu
    (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_start         (alu_start),
        .i_alu_a         (o_alu_a),
        .i_alu_b         (o_alu_b),
        .i_alu_op        (o_alu_op),
        .o_alu_result    (o_alu_result),
        .o_overflow_flag (o_overflow_flag),
        .o_result_valid  (o_result_valid)
    );

endmodule

//--- sim/alu_top_tb.sv
`timescale 1ns/1ps

module alu_top_tb
    import alu_lab_pkg::*;
();

    localparam int N_TABLE      = 17;
    localparam int N_RANDOM     = 40;
    localparam int RESET_CYCLES = 8;
    // Two directed sequences count as extra rows
    localparam int TIMEOUT_CYCLES = (N_TABLE + N_RANDOM + 4) * 60 + RESET_CYCLES;

    localparam int BTN_A  = 0;
    localparam int BTN_B  = 1;
    localparam int BTN_OP = 2;

    // Known codes for the random rows
    localparam alu_op_t OP_LIST [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
                                        OP_XOR, OP_NOR, OP_SRA, OP_SRL};

    // One stimulus row with its expected response
    typedef struct packed
    {
        operand_t a;
        operand_t b;
        alu_op_t  op;
        operand_t res;
        logic     ovf;
    } row_t;

    logic     i_clock;
    logic     i_rst;
    switch_t  i_sw;
    logic     i_button_a;
    logic     i_button_b;
    logic     i_button_op;
    operand_t o_alu_a;
    operand_t o_alu_b;
    alu_op_t  o_alu_op;
    operand_t o_alu_result;
    logic     o_overflow_flag;
    logic     o_result_valid;

    row_t        rows [N_TABLE];
    int          cycle_count;
    operand_t    rnd_a;
    operand_t    rnd_b;
    alu_op_t     rnd_op;
    logic [4:0]  rnd_exp;
    int          rnd_idx;
    operand_t    prev_b;
    alu_op_t     prev_op;

    alu_top dut
    (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_sw            (i_sw),
        .i_button_a      (i_button_a),
        .i_button_b      (i_button_b),
        .i_button_op     (i_button_op),
        .o_alu_a         (o_alu_a),
        .o_alu_b         (o_alu_b),
        .o_alu_op        (o_alu_op),
        .o_alu_result    (o_alu_result),
        .o_overflow_flag (o_overflow_flag),
        .o_result_valid  (o_result_valid)
    );

    // 40 ns clock
    always #20 i_clock = ~i_clock;

    // Run limit
    always @(posedge i_clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: o_result_valid never arrived within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic set_button(input int which, input logic level);
        case (which)
            BTN_A:   i_button_a = level;
            BTN_B:   i_button_b = level;
            default: i_button_op = level;
        endcase
    endtask

    // Press for some cycles, then two low cycles
    task automatic press(input int which, input int hold_cycles);
        set_button(which, 1'b1);
        repeat (hold_cycles) @(negedge i_clock);
        set_button(which, 1'b0);
        repeat (2) @(negedge i_clock);
    endtask

    // Valid must pulse once with the expected result
    task automatic collect_result(input operand_t exp_res, input logic exp_ovf);
        while (o_result_valid !== 1'b1)
            @(negedge i_clock);
        check_value("o_alu_result", 32'(o_alu_result), 32'(exp_res));
        check_value("o_overflow_flag", 32'(o_overflow_flag), 32'(exp_ovf));
        @(negedge i_clock);
        check_value("o_result_valid width", 32'(o_result_valid), 32'd0);
    endtask

    task automatic run_op(input operand_t a, input operand_t b, input alu_op_t op,
                          input operand_t exp_res, input logic exp_ovf);
        i_sw = {2'b00, op, b, a};
        press(BTN_A, 2);
        check_value("o_alu_a", 32'(o_alu_a), 32'(a));
        press(BTN_B, 2);
        check_value("o_alu_b", 32'(o_alu_b), 32'(b));
        press(BTN_OP, 2);
        check_value("o_alu_op", 32'(o_alu_op), 32'(op));
        collect_result(exp_res, exp_ovf);
    endtask

    // Reference ALU, overflow from the true signed range
    function automatic logic [4:0] model_alu(input operand_t a, input operand_t b,
                                             input alu_op_t op);
        int       sa;
        int       sb;
        int       wide;
        operand_t res;
        logic     ovf;
        sa  = int'($signed(a));
        sb  = int'($signed(b));
        res = '0;
        ovf = 1'b0;
        case (op)
            OP_ADD:
            begin
                wide = sa + sb;
                res  = operand_t'(wide);
                ovf  = (wide > 7) || (wide < -8);
            end
            OP_SUB:
            begin
                wide = sa - sb;
                res  = operand_t'(wide);
                ovf  = (wide > 7) || (wide < -8);
            end
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_XOR: res = a ^ b;
            OP_NOR: res = ~(a | b);
            // Int shift keeps filling with the sign past 4 places
            OP_SRA: res = operand_t'(sa >>> b);
            OP_SRL: res = (int'(b) >= DATA_W) ? '0 : (a >> b);
            default: res = '0;
        endcase
        return {ovf, res};
    endfunction

    // Hand-picked rows: every opcode and the overflow corners
    task automatic fill_table();
        rows[0]  = '{4'h7, 4'h1, OP_ADD, 4'h8, 1'b1};
        rows[1]  = '{4'h3, 4'h2, OP_ADD, 4'h5, 1'b0};
        // -8 + -1
        rows[2]  = '{4'h8, 4'hF, OP_ADD, 4'h7, 1'b1};
        // Carry out but no signed overflow
        rows[3]  = '{4'hF, 4'h1, OP_ADD, 4'h0, 1'b0};
        // -8 - 1
        rows[4]  = '{4'h8, 4'h1, OP_SUB, 4'h7, 1'b1};
        rows[5]  = '{4'h2, 4'h3, OP_SUB, 4'hF, 1'b0};
        // 7 - (-1)
        rows[6]  = '{4'h7, 4'hF, OP_SUB, 4'h8, 1'b1};
        rows[7]  = '{4'hC, 4'hA, OP_AND, 4'h8, 1'b0};
        rows[8]  = '{4'hC, 4'hA, OP_OR,  4'hE, 1'b0};
        rows[9]  = '{4'hC, 4'hA, OP_XOR, 4'h6, 1'b0};
        rows[10] = '{4'hC, 4'hA, OP_NOR, 4'h1, 1'b0};
        rows[11] = '{4'h8, 4'h1, OP_SRA, 4'hC, 1'b0};
        // Past the width, all sign bits
        rows[12] = '{4'h8, 4'h5, OP_SRA, 4'hF, 1'b0};
        rows[13] = '{4'h6, 4'h1, OP_SRA, 4'h3, 1'b0};
        rows[14] = '{4'h8, 4'h1, OP_SRL, 4'h4, 1'b0};
        rows[15] = '{4'hF, 4'h4, OP_SRL, 4'h0, 1'b0};
        // Undefined code
        rows[16] = '{4'hF, 4'hF, 6'b111111, 4'h0, 1'b0};
    endtask

    initial
    begin
        i_clock     = 1'b0;
        i_rst       = 1'b1;
        i_sw        = '0;
        i_button_a  = 1'b0;
        i_button_b  = 1'b0;
        i_button_op = 1'b0;
        cycle_count = 0;
        void'($urandom(32'h59a8b9f9));
        fill_table();

        repeat (RESET_CYCLES) @(negedge i_clock);
        i_rst = 1'b0;

        // Idle outputs after reset
        @(negedge i_clock);
        check_value("o_alu_a after reset", 32'(o_alu_a), 32'd0);
        check_value("o_alu_b after reset", 32'(o_alu_b), 32'd0);
        check_value("o_alu_op after reset", 32'(o_alu_op), 32'd0);
        check_value("o_alu_result after reset", 32'(o_alu_result), 32'd0);
        check_value("o_overflow_flag after reset", 32'(o_overflow_flag), 32'd0);
        repeat (4)
        begin
            check_value("o_result_valid idle", 32'(o_result_valid), 32'd0);
            @(negedge i_clock);
        end

        for (int i = 0; i < N_TABLE; i++)
            run_op(rows[i].a, rows[i].b, rows[i].op, rows[i].res, rows[i].ovf);

        // B and opcode while waiting for A
        prev_b  = o_alu_b;
        prev_op = o_alu_op;
        i_sw    = {2'b00, OP_SUB, 4'h9, 4'h3};
        press(BTN_B, 2);
        press(BTN_OP, 2);
        repeat (6)
        begin
            check_value("o_result_valid out of order", 32'(o_result_valid), 32'd0);
            @(negedge i_clock);
        end
        check_value("o_alu_b out of order", 32'(o_alu_b), 32'(prev_b));
        check_value("o_alu_op out of order", 32'(o_alu_op), 32'(prev_op));
        // 3 - (-7) overflows
        run_op(4'h3, 4'h9, OP_SUB, 4'hA, 1'b1);

        // Long press of A, switches move after the load
        i_sw = {2'b00, OP_ADD, 4'h2, 4'h5};
        set_button(BTN_A, 1'b1);
        repeat (5) @(negedge i_clock);
        i_sw[SW_A_LSB +: DATA_W] = 4'hA;
        // A stays down through the whole operation
        press(BTN_B, 2);
        press(BTN_OP, 2);
        collect_result(4'h7, 1'b0);
        // Back in ST_WAIT_A with A still high, a second pulse would load 4'hA
        repeat (6) @(negedge i_clock);
        check_value("o_alu_a held press", 32'(o_alu_a), 32'h5);
        set_button(BTN_A, 1'b0);
        repeat (2) @(negedge i_clock);

        for (int i = 0; i < N_RANDOM; i++)
        begin
            rnd_a   = operand_t'($urandom);
            rnd_b   = operand_t'($urandom);
            rnd_idx = $urandom % 10;
            if (i == 0)
                rnd_op = 6'b011111;
            else if (rnd_idx >= 8)
                rnd_op = alu_op_t'($urandom);
            else
                rnd_op = OP_LIST[rnd_idx];
            rnd_exp = model_alu(rnd_a, rnd_b, rnd_op);
            run_op(rnd_a, rnd_b, rnd_op, rnd_exp[DATA_W-1:0], rnd_exp[DATA_W]);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- tb.f
source/alu_lab_pkg.sv
source/button_pulse.sv
source/alu_input_ctrl.sv
source/alu.sv
source/alu_top.sv
sim/alu_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= alu_top_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
